// ==== filelist.f ====
accum_pkg.sv
chunk_write_sequencer.sv
chunk_buffer_ram.sv
chunk_queue.sv
payload_reader.sv
accum_wb_regs.sv
event_accumulator_top.sv
tb_clock_gen.sv
tb_accum_assertions.sv
tb_event_accumulator.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_event_accumulator
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q -F '>>> FAIL' $(LOG) || \
	   ! grep -q -F '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_event_accumulator.sv ====
module tb_event_accumulator;
    import accum_pkg::*;

    localparam int SAMPLES      = 8;
    localparam int DRIVE_DELAY  = 1;
    localparam int NUM_EVENTS   = 3;
    // words per chunk, per event and per lane within one event
    localparam int CHUNK_WORDS  = NUM_SURFS * SAMPLES;
    localparam int EVENT_WORDS  = CHUNKS_PER_EVENT * CHUNK_WORDS;
    localparam int LANE_WORDS   = CHUNKS_PER_EVENT * SAMPLES;
    localparam int TOTAL_WORDS  = NUM_EVENTS * EVENT_WORDS;
    localparam int IDLE_CYCLES  = 40;
    // a round of 7 words takes well under 4 cycles per word even with gaps
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + 1000;

    logic                              memclk;
    logic                              memresetn;
    surf_word_t [NUM_SURFS-1:0]        surf_data;
    logic [NUM_SURFS-1:0]              surf_valid;
    logic [NUM_SURFS-1:0]              surf_ready;
    surf_word_t                        payload_data;
    logic                              payload_valid;
    payload_user_t                     payload_user;
    logic                              payload_last;
    logic                              payload_ready;
    logic                              wb_cyc;
    logic                              wb_stb;
    logic                              wb_we;
    wb_adr_t                           wb_adr;
    wb_data_t                          wb_dat_w;
    wb_data_t                          wb_dat_r;
    logic                              wb_ack;

    int          errors;
    int          gap_errors;
    int          tests_failed;
    int          words_seen;
    int          word_limit;
    logic [31:0] lfsr_state;

    tb_clock_gen u_tb_clock_gen (
        .memclk   (memclk),
        .memresetn(memresetn)
    );

    event_accumulator_top #(
        .samples_per_chunk(SAMPLES)
    ) u_event_accumulator_top (
        .memclk       (memclk),
        .memresetn    (memresetn),
        .surf_data    (surf_data),
        .surf_valid   (surf_valid),
        .surf_ready   (surf_ready),
        .payload_data (payload_data),
        .payload_valid(payload_valid),
        .payload_user (payload_user),
        .payload_last (payload_last),
        .payload_ready(payload_ready),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    // word j of lane k in event ev
    function automatic surf_word_t ref_word(input int ev, input int lane, input int j);
        logic [31:0] mix;
        mix = (32'(lane) * 32'h0100_0193) ^ (32'(j) * 32'h9e37_79b9) ^ (32'(ev) << 20);
        return {8'h5a, 8'(ev), 8'(lane), 8'(j), mix};
    endfunction

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // two bits per gap, one step per bit
    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        bits = '0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[0], lfsr_state[0]};
        end
        gap = int'(bits);
    endtask

    task automatic check_word(input string name, input surf_word_t got, input surf_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_user(input string name, input payload_user_t got,
                              input payload_user_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // classic cycle, held until ack
    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                              output wb_data_t rdata);
        int waited;
        waited = 0;
        @(posedge memclk);
        #DRIVE_DELAY;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge memclk);
        while (!wb_ack && waited < 8) begin
            @(negedge memclk);
            waited++;
        end
        if (!wb_ack) begin
            errors++;
            $display("wishbone access to register %0d at %0t got no ack", adr, $time);
        end
        rdata = wb_dat_r;
        @(posedge memclk);
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_write(input wb_adr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic reg_read(input wb_adr_t adr, output wb_data_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic report_test(input int num, input string name, input int count);
        if (count == 0) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, count);
        end
    endtask

    // lane drivers, one word per lane held until taken, random gaps after each
    initial begin
        int                   next_idx [NUM_SURFS];
        int                   gap [NUM_SURFS];
        logic [NUM_SURFS-1:0] take;
        surf_data  = '0;
        surf_valid = '0;
        lfsr_state = 32'h8e68_fae1;
        for (int k = 0; k < NUM_SURFS; k++) begin
            next_idx[k] = 0;
            gap[k]      = 0;
        end
        wait (memresetn == 1'b1);
        forever begin
            // handshake values are stable mid cycle
            @(negedge memclk);
            take = surf_ready & surf_valid;
            @(posedge memclk);
            #DRIVE_DELAY;
            for (int k = 0; k < NUM_SURFS; k++) begin
                if (take[k]) begin
                    next_idx[k]++;
                    surf_valid[k] = 1'b0;
                    draw_gap(gap[k]);
                end else if (!surf_valid[k]) begin
                    if (gap[k] > 0) begin
                        gap[k]--;
                    end else if (next_idx[k] < word_limit) begin
                        surf_data[k]  = ref_word(next_idx[k] / LANE_WORDS, k,
                                                 next_idx[k] % LANE_WORDS);
                        surf_valid[k] = 1'b1;
                    end
                end
            end
        end
    end

    // comparing process for the payload stream
    initial begin
        int rem;
        int chunk;
        int surf;
        int smp;
        words_seen = 0;
        gap_errors = 0;
        wait (memresetn == 1'b1);
        forever begin
            @(negedge memclk);
            if (payload_valid) begin
                if (words_seen >= TOTAL_WORDS) begin
                    errors++;
                    $display("payload word at %0t beyond the expected stream", $time);
                end else begin
                    rem   = words_seen % EVENT_WORDS;
                    chunk = rem / CHUNK_WORDS;
                    surf  = (rem % CHUNK_WORDS) / SAMPLES;
                    smp   = rem % SAMPLES;
                    check_word("payload_data", payload_data,
                               ref_word(words_seen / EVENT_WORDS, surf, chunk * SAMPLES + smp));
                    check_user("payload_user", payload_user,
                               {chunk_t'(chunk), surf_idx_t'(surf)});
                    check_flag("payload_last", payload_last, smp == SAMPLES - 1);
                end
                words_seen++;
            end else if (words_seen % CHUNK_WORDS != 0) begin
                // a chunk must come out without a break
                gap_errors++;
                errors++;
                $display("payload_valid dropped at %0t after %0d words of a chunk",
                         $time, words_seen % CHUNK_WORDS);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge memclk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        wb_data_t rd;
        int       e0;
        int       g0;
        errors        = 0;
        tests_failed  = 0;
        word_limit    = 0;
        payload_ready = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        wait (memresetn == 1'b1);
        @(posedge memclk);

        // reset values, then ctrl read back
        e0 = errors;
        reg_read(2'd0, rd);
        check_reg("ctrl", rd, 32'd0);
        reg_read(2'd1, rd);
        check_reg("status", rd, 32'd0);
        reg_read(2'd2, rd);
        check_reg("chunks_written", rd, 32'd0);
        reg_read(2'd3, rd);
        check_reg("chunks_read", rd, 32'd0);
        reg_write(2'd0, 32'd1);
        reg_read(2'd0, rd);
        check_reg("ctrl", rd, 32'd1);
        reg_write(2'd0, 32'd0);
        reg_read(2'd0, rd);
        check_reg("ctrl", rd, 32'd0);
        report_test(1, "registers", errors - e0);

        // lanes full of words, sequencer held off
        e0 = errors;
        word_limit = 2 * LANE_WORDS;
        repeat (IDLE_CYCLES) begin
            @(negedge memclk);
            if (surf_ready != '0) begin
                errors++;
                $display("surf_ready strobed at %0t while enable is low", $time);
            end
            if (payload_valid) begin
                errors++;
                $display("payload appeared at %0t while enable is low", $time);
            end
        end
        report_test(2, "disabled", errors - e0);

        // two events through the buffer
        e0 = errors;
        g0 = gap_errors;
        reg_write(2'd0, 32'd1);
        while (words_seen < 2 * EVENT_WORDS) @(posedge memclk);
        report_test(3, "ordering", (errors - e0) - (gap_errors - g0));
        report_test(4, "readout", gap_errors - g0);

        // let the last chunk_read reach the counter
        e0 = errors;
        repeat (4) @(posedge memclk);
        reg_read(2'd2, rd);
        check_reg("chunks_written", rd, 32'd8);
        reg_read(2'd3, rd);
        check_reg("chunks_read", rd, 32'd8);
        report_test(5, "counters", errors - e0);

        // third event, ready dropped for one valid cycle
        e0 = errors;
        word_limit = NUM_EVENTS * LANE_WORDS;
        while (words_seen <= 2 * EVENT_WORDS) @(posedge memclk);
        #DRIVE_DELAY payload_ready = 1'b0;
        @(posedge memclk);
        #DRIVE_DELAY payload_ready = 1'b1;
        reg_read(2'd1, rd);
        check_reg("status", rd, 32'd1);
        reg_write(2'd1, 32'd1);
        reg_read(2'd1, rd);
        check_reg("status", rd, 32'd0);
        while (words_seen < TOTAL_WORDS) @(posedge memclk);
        report_test(6, "overflow", errors - e0);

        $display("tests run 6, tests failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_accum_assertions.sv ====
module tb_accum_assertions (
    input logic       memclk,
    input logic       memresetn,
    input logic [6:0] surf_valid,
    input logic [6:0] surf_ready,
    input logic       payload_valid,
    input logic       payload_last,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       push,
    input logic       q_valid,
    input logic       q_pop
);

    // occupancy of the chunk queue, tracked from its push and pop strobes
    logic [2:0] q_count;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            q_count <= '0;
        end else begin
            q_count <= q_count + 3'(push) - 3'(q_pop && q_valid);
        end
    end

    // one lane strobed per cycle at most, and never a lane without a word
    a_single_ready: assert property (@(posedge memclk) disable iff (!memresetn)
        $onehot0(surf_ready) && ((surf_ready & ~surf_valid) == '0))
        else $error("surf_ready strobe on more than one lane or on an empty lane");

    a_last_with_valid: assert property (@(posedge memclk) disable iff (!memresetn)
        payload_last |-> payload_valid)
        else $error("payload_last high without payload_valid");

    a_ack_in_cycle: assert property (@(posedge memclk) disable iff (!memresetn)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside a bus cycle");

    // four entries deep
    a_no_push_full: assert property (@(posedge memclk) disable iff (!memresetn)
        push |-> (q_count < 3'd4))
        else $error("chunk queue pushed while full");

endmodule

bind event_accumulator_top tb_accum_assertions u_tb_accum_assertions (
    .memclk       (memclk),
    .memresetn    (memresetn),
    .surf_valid   (surf_valid),
    .surf_ready   (surf_ready),
    .payload_valid(payload_valid),
    .payload_last (payload_last),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .push         (chunk_done),
    .q_valid      (q_valid),
    .q_pop        (q_pop)
);

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic memclk,
    output logic memresetn
);

    // 10 time unit period
    initial begin
        memclk = 1'b0;
        forever begin
            #5 memclk = ~memclk;
        end
    end

    // reset held low for the first 5 rising edges
    initial begin
        memresetn = 1'b0;
        repeat (5) @(posedge memclk);
        #1 memresetn = 1'b1;
    end

endmodule

// ==== event_accumulator_top.sv ====
module event_accumulator_top #(
    parameter int samples_per_chunk = 384
) (
    input  logic                                             memclk,
    input  logic                                             memresetn,
    input  accum_pkg::surf_word_t [accum_pkg::NUM_SURFS-1:0] surf_data,
    input  logic [accum_pkg::NUM_SURFS-1:0]                  surf_valid,
    output logic [accum_pkg::NUM_SURFS-1:0]                  surf_ready,
    output accum_pkg::surf_word_t                            payload_data,
    output logic                                             payload_valid,
    output accum_pkg::payload_user_t                         payload_user,
    output logic                                             payload_last,
    input  logic                                             payload_ready,
    input  logic                                             wb_cyc,
    input  logic                                             wb_stb,
    input  logic                                             wb_we,
    input  accum_pkg::wb_adr_t                               wb_adr,
    input  accum_pkg::wb_data_t                              wb_dat_w,
    output accum_pkg::wb_data_t                              wb_dat_r,
    output logic                                             wb_ack
);
    import accum_pkg::*;

    logic       enable;
    // write side
    logic       wr_en;
    buf_addr_t  wr_addr;
    surf_word_t wr_data;
    logic       chunk_done;
    chunk_t     done_chunk;
    // queue to reader
    logic       q_valid;
    chunk_t     q_chunk;
    logic       q_pop;
    // read side
    logic       rd_en;
    buf_addr_t  rd_addr;
    surf_word_t rd_data;
    logic       overflow_event;
    logic       chunk_read;

    chunk_write_sequencer #(
        .samples_per_chunk(samples_per_chunk)
    ) u_chunk_write_sequencer (
        .memclk    (memclk),
        .memresetn (memresetn),
        .enable    (enable),
        .surf_data (surf_data),
        .surf_valid(surf_valid),
        .surf_ready(surf_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .chunk_done(chunk_done),
        .done_chunk(done_chunk)
    );

    chunk_buffer_ram u_chunk_buffer_ram (
        .memclk (memclk),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    chunk_queue u_chunk_queue (
        .memclk    (memclk),
        .memresetn (memresetn),
        .push      (chunk_done),
        .push_chunk(done_chunk),
        .q_valid   (q_valid),
        .q_chunk   (q_chunk),
        .q_pop     (q_pop)
    );

    payload_reader #(
        .samples_per_chunk(samples_per_chunk)
    ) u_payload_reader (
        .memclk        (memclk),
        .memresetn     (memresetn),
        .q_valid       (q_valid),
        .q_chunk       (q_chunk),
        .q_pop         (q_pop),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .payload_data  (payload_data),
        .payload_valid (payload_valid),
        .payload_user  (payload_user),
        .payload_last  (payload_last),
        .payload_ready (payload_ready),
        .overflow_event(overflow_event),
        .chunk_read    (chunk_read)
    );

    accum_wb_regs u_accum_wb_regs (
        .memclk        (memclk),
        .memresetn     (memresetn),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .enable        (enable),
        .chunk_done    (chunk_done),
        .overflow_event(overflow_event),
        .chunk_read    (chunk_read)
    );

endmodule

// ==== accum_wb_regs.sv ====
module accum_wb_regs (
    input  logic                memclk,
    input  logic                memresetn,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  accum_pkg::wb_adr_t  wb_adr,
    input  accum_pkg::wb_data_t wb_dat_w,
    output accum_pkg::wb_data_t wb_dat_r,
    output logic                wb_ack,
    output logic                enable,
    input  logic                chunk_done,
    input  logic                overflow_event,
    input  logic                chunk_read
);
    import accum_pkg::*;

    logic        ctrl_enable;
    logic        overflow_flag;
    logic [15:0] written_cnt;
    logic [15:0] read_cnt;
    logic        access;
    logic        wr_access;
    wb_data_t    rd_word;

    // one access per cycle, the ack cycle itself does not start another
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign wr_access = access && wb_we;
    assign enable    = ctrl_enable;

    always_comb begin
        case (wb_adr)
            2'd0:    rd_word = {31'b0, ctrl_enable};
            2'd1:    rd_word = {31'b0, overflow_flag};
            2'd2:    rd_word = {16'b0, written_cnt};
            default: rd_word = {16'b0, read_cnt};
        endcase
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wb_ack        <= 1'b0;
            ctrl_enable   <= 1'b0;
            overflow_flag <= 1'b0;
            written_cnt   <= '0;
            read_cnt      <= '0;
        end else begin
            wb_ack <= access;
            if (wr_access && wb_adr == 2'd0) begin
                ctrl_enable <= wb_dat_w[0];
            end
            // a new overflow wins over a clear in the same cycle
            if (overflow_event) begin
                overflow_flag <= 1'b1;
            end else if (wr_access && wb_adr == 2'd1 && wb_dat_w[0]) begin
                overflow_flag <= 1'b0;
            end
            // both counters wrap
            if (chunk_done) begin
                written_cnt <= written_cnt + 1'b1;
            end
            if (chunk_read) begin
                read_cnt <= read_cnt + 1'b1;
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge memclk) begin
        if (access) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

// ==== payload_reader.sv ====
module payload_reader #(
    parameter int samples_per_chunk = 384
) (
    input  logic                     memclk,
    input  logic                     memresetn,
    input  logic                     q_valid,
    input  accum_pkg::chunk_t        q_chunk,
    output logic                     q_pop,
    output logic                     rd_en,
    output accum_pkg::buf_addr_t     rd_addr,
    input  accum_pkg::surf_word_t    rd_data,
    output accum_pkg::surf_word_t    payload_data,
    output logic                     payload_valid,
    output accum_pkg::payload_user_t payload_user,
    output logic                     payload_last,
    input  logic                     payload_ready,
    output logic                     overflow_event,
    output logic                     chunk_read
);
    import accum_pkg::*;

    logic                  active;
    chunk_t                chunk;
    surf_idx_t             surf;
    sample_cnt_t           sample;
    buf_addr_t             addr;
    logic                  run_last;
    logic                  final_word;
    // one stage per memory cycle plus the payload register
    logic [READ_LATENCY:0] valid_pipe;
    logic [READ_LATENCY:0] last_pipe;
    payload_user_t         user_pipe [READ_LATENCY+1];

    // pop only between chunks
    assign q_pop    = !active && q_valid;
    assign rd_en    = active;
    assign rd_addr  = addr;
    // last sample of the current SURF's run
    assign run_last = active && (sample == sample_cnt_t'(samples_per_chunk - 1));

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            active <= 1'b0;
            chunk  <= '0;
            surf   <= '0;
            sample <= '0;
            addr   <= '0;
        end else if (q_pop) begin
            active <= 1'b1;
            chunk  <= q_chunk;
            surf   <= '0;
            sample <= '0;
            addr   <= q_chunk[0] ? BANK_WORDS : '0;
        end else if (active) begin
            // the bank is laid out in readout order, so plain increment
            addr <= addr + 1'b1;
            if (run_last) begin
                sample <= '0;
                surf   <= surf + 1'b1;
                if (surf == surf_idx_t'(NUM_SURFS - 1)) begin
                    active <= 1'b0;
                end
            end else begin
                sample <= sample + 1'b1;
            end
        end
    end

    // control bits follow the data through the memory
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
            chunk_read <= 1'b0;
        end else begin
            valid_pipe <= {valid_pipe[READ_LATENCY-1:0], rd_en};
            last_pipe  <= {last_pipe[READ_LATENCY-1:0], run_last};
            chunk_read <= final_word;
        end
    end

    always_ff @(posedge memclk) begin
        user_pipe[0] <= {chunk, surf};
        for (int i = 1; i <= READ_LATENCY; i++) begin
            user_pipe[i] <= user_pipe[i-1];
        end
        payload_data <= rd_data;
    end

    assign payload_valid = valid_pipe[READ_LATENCY];
    assign payload_last  = last_pipe[READ_LATENCY];
    assign payload_user  = user_pipe[READ_LATENCY];

    // end of the last SURF's run closes the chunk
    assign final_word = payload_valid && payload_last &&
                        (payload_user[2:0] == surf_idx_t'(NUM_SURFS - 1));
    // no backpressure, a word without ready is dropped
    assign overflow_event = payload_valid && !payload_ready;

endmodule

// ==== chunk_queue.sv ====
module chunk_queue (
    input  logic              memclk,
    input  logic              memresetn,
    input  logic              push,
    input  accum_pkg::chunk_t push_chunk,
    output logic              q_valid,
    output accum_pkg::chunk_t q_chunk,
    input  logic              q_pop
);
    import accum_pkg::*;

    localparam int DEPTH = 4;

    chunk_t     entries [DEPTH];
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;
    logic       full;
    logic       do_push;
    logic       do_pop;

    assign full    = (count == 3'(DEPTH));
    // a push into a full queue is lost
    assign do_push = push && !full;
    assign do_pop  = q_pop && q_valid;
    assign q_valid = (count != '0);
    // first-word fall-through
    assign q_chunk = entries[rd_ptr];

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge memclk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_chunk;
        end
    end

endmodule

// ==== chunk_buffer_ram.sv ====
module chunk_buffer_ram (
    input  logic                  memclk,
    input  logic                  wr_en,
    input  accum_pkg::buf_addr_t  wr_addr,
    input  accum_pkg::surf_word_t wr_data,
    input  logic                  rd_en,
    input  accum_pkg::buf_addr_t  rd_addr,
    output accum_pkg::surf_word_t rd_data
);
    import accum_pkg::*;

    // both banks in one array
    localparam int DEPTH = 2 * int'(BANK_WORDS);

    surf_word_t mem [DEPTH];
    surf_word_t rd_q;

    // write port
    always_ff @(posedge memclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, array register then output register
    always_ff @(posedge memclk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
        rd_data <= rd_q;
    end

endmodule

// ==== chunk_write_sequencer.sv ====
module chunk_write_sequencer #(
    parameter int samples_per_chunk = 384
) (
    input  logic                                             memclk,
    input  logic                                             memresetn,
    input  logic                                             enable,
    input  accum_pkg::surf_word_t [accum_pkg::NUM_SURFS-1:0] surf_data,
    input  logic [accum_pkg::NUM_SURFS-1:0]                  surf_valid,
    output logic [accum_pkg::NUM_SURFS-1:0]                  surf_ready,
    output logic                                             wr_en,
    output accum_pkg::buf_addr_t                             wr_addr,
    output accum_pkg::surf_word_t                            wr_data,
    output logic                                             chunk_done,
    output accum_pkg::chunk_t                                done_chunk
);
    import accum_pkg::*;

    seq_state_t  state;
    sample_cnt_t sample;
    chunk_t      chunk;
    surf_idx_t   slot;
    buf_addr_t   addr_q;
    buf_addr_t   bank_base;
    logic        all_valid;
    logic        last_sample;

    // every lane must hold a word before a round starts
    assign all_valid   = &surf_valid;
    assign last_sample = (sample == sample_cnt_t'(samples_per_chunk - 1));
    // low bit of the chunk picks the bank
    assign bank_base   = chunk[0] ? BANK_WORDS : '0;

    // write slots are contiguous in the enum, slot index falls out of the state
    assign wr_en      = (state >= ST_WRITE0) && (state <= ST_WRITE6);
    assign slot       = surf_idx_t'(state - ST_WRITE0);
    // single ready strobe, only for the lane of the current slot
    assign surf_ready = wr_en ? (NUM_SURFS'(1) << slot) : '0;
    assign wr_data    = surf_data[slot];
    assign wr_addr    = addr_q;

    assign chunk_done = (state == ST_SIGNAL);
    assign done_chunk = chunk;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state  <= ST_IDLE;
            sample <= '0;
            chunk  <= '0;
            addr_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    sample <= '0;
                    chunk  <= '0;
                    // lane 0 valid marks the start of an event
                    if (enable && surf_valid[0]) begin
                        state <= ST_PREP;
                    end
                end
                ST_PREP: begin
                    // lane 0 address for the coming round
                    addr_q <= bank_base + buf_addr_t'(sample);
                    if (all_valid) begin
                        state <= ST_WRITE0;
                    end
                end
                ST_WRITE6: begin
                    if (last_sample) begin
                        sample <= '0;
                        state  <= ST_SIGNAL;
                    end else begin
                        sample <= sample + 1'b1;
                        // always wait for a full set of valids again
                        state  <= ST_PREP;
                    end
                end
                ST_SIGNAL: begin
                    chunk <= chunk + 1'b1;
                    if (chunk == chunk_t'(CHUNKS_PER_EVENT - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_PREP;
                    end
                end
                default: begin
                    // slots 0 to 5, next lane sits one run further up
                    addr_q <= addr_q + buf_addr_t'(samples_per_chunk);
                    state  <= seq_state_t'(state + 1);
                end
            endcase
        end
    end

endmodule

// ==== accum_pkg.sv ====
package accum_pkg;

    // fixed counts of the accumulator
    localparam int NUM_SURFS        = 7;
    localparam int CHUNKS_PER_EVENT = 4;
    // buffer read latency in memclk cycles
    localparam int READ_LATENCY     = 2;
    // largest run of samples one SURF puts into one chunk
    localparam int MAX_SAMPLES      = 384;

    typedef logic [63:0] surf_word_t;
    // two banks of 7 x 384 words
    typedef logic [12:0] buf_addr_t;
    typedef logic [8:0]  sample_cnt_t;
    typedef logic [1:0]  chunk_t;
    typedef logic [2:0]  surf_idx_t;
    // chunk number on top, surf index below
    typedef logic [4:0]  payload_user_t;
    typedef logic [1:0]  wb_adr_t;
    typedef logic [31:0] wb_data_t;

    // start of bank 1, bank 0 sits at zero
    localparam buf_addr_t BANK_WORDS = buf_addr_t'(NUM_SURFS * MAX_SAMPLES);

    // one write slot per SURF lane
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_PREP,
        ST_WRITE0,
        ST_WRITE1,
        ST_WRITE2,
        ST_WRITE3,
        ST_WRITE4,
        ST_WRITE5,
        ST_WRITE6,
        ST_SIGNAL
    } seq_state_t;

endpackage
